// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] bus32_t;

    // J-type field layout, msb first
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        bus32_t  raw;
        j_type_t j;
    } instr_u;

    localparam instr_u     NOP_INSTR      = instr_u'(32'h0000_0013);  // addi x0, x0, 0
    localparam logic [6:0] OPCODE_JAL     = 7'b110_1111;
    localparam logic [2:0] AXI_PROT_INSTR = 3'b100;                  // Unprivileged, secure, instr
    localparam bus32_t     RESET_PC       = 32'h0000_0000;

    typedef struct packed {
        bus32_t pc;
        instr_u instr;
    } fetch_out_t;

    typedef struct packed {
        bus32_t addr;  // Word aligned
    } mem_req_t;

    typedef struct packed {
        bus32_t addr;
        instr_u data;
    } mem_rsp_t;

    typedef struct packed {
        bus32_t     araddr;
        logic [2:0] arprot;
    } axil_ar_t;

    typedef struct packed {
        bus32_t     rdata;
        logic [1:0] rresp;
    } axil_r_t;

    // Sign-extended J immediate, bit 0 always zero
    function automatic bus32_t j_imm(instr_u instr);
        j_type_t j;
        j = instr.j;
        return {{11{j.imm20}}, j.imm20, j.imm19_12, j.imm11, j.imm10_1, 1'b0};
    endfunction

endpackage

`default_nettype wire

// File: logic/pc_gen.sv
`default_nettype none

module pc_gen (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  hit_i,
    input  fetch_pkg::instr_u     instr_i,
    input  logic                  out_ready_i,
    input  logic                  redirect_valid_i,
    input  fetch_pkg::bus32_t     redirect_pc_i,
    output fetch_pkg::bus32_t     pc_o,
    output fetch_pkg::fetch_out_t out_o,
    output logic                  out_valid_o
);
    import fetch_pkg::*;

    bus32_t pc_q;
    bus32_t pc_follow;
    bus32_t pc_next;
    logic   transfer;
    logic   is_jal;

    assign transfer = hit_i && out_ready_i;
    assign is_jal   = (instr_i.j.opcode == OPCODE_JAL);

    // Predecode: JAL target or fall through
    assign pc_follow = is_jal ? (pc_q + j_imm(instr_i)) : (pc_q + 32'd4);

    always_comb begin
        pc_next = pc_q;
        if (redirect_valid_i) begin
            pc_next = redirect_pc_i;  // Later stage wins
        end else if (transfer) begin
            pc_next = pc_follow;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o        = pc_q;
    assign out_valid_o = hit_i;
    assign out_o.pc    = pc_q;
    assign out_o.instr = instr_i;  // Stable under back-pressure since pc_q holds

endmodule

`default_nettype wire

// File: logic/icache.sv
`default_nettype none

module icache #(
    parameter int NUM_SETS = 16,
    parameter int WAYS     = 2
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  fetch_pkg::bus32_t   pc_i,
    input  logic                accept_i,
    output logic                hit_o,
    output fetch_pkg::instr_u   instr_o,
    output logic                req_valid_o,
    input  logic                req_ready_i,
    output fetch_pkg::mem_req_t req_o,
    input  logic                rsp_valid_i,
    input  fetch_pkg::mem_rsp_t rsp_i
);
    import fetch_pkg::*;

    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int WAY_BITS    = (WAYS > 1) ? $clog2(WAYS) : 1;

    localparam logic [WAY_BITS-1:0] OLDEST = WAY_BITS'(WAYS - 1);

    logic                valid_q [NUM_SETS][WAYS];
    logic [TAG_BITS-1:0] tag_q   [NUM_SETS][WAYS];
    instr_u              data_q  [NUM_SETS][WAYS];
    logic [WAY_BITS-1:0] age_q   [NUM_SETS][WAYS];  // 0 is most recent

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    bus32_t                line_addr;
    logic [WAYS-1:0]       hit_vec;
    logic [WAY_BITS-1:0]   hit_way;
    logic [WAY_BITS-1:0]   victim_way;
    logic [WAY_BITS-1:0]   touch_way;
    logic                  hit;
    logic                  fill;
    logic                  touch_en;
    logic                  pending_q;

    assign index     = pc_i[OFFSET_BITS +: INDEX_BITS];
    assign tag       = pc_i[31 -: TAG_BITS];
    assign line_addr = {pc_i[31:OFFSET_BITS], 2'b00};

    // Parallel tag compare over all ways of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (hit_vec[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    always_comb begin
        victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (age_q[index][w] == OLDEST) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    assign hit     = |hit_vec;
    assign hit_o   = hit;
    assign instr_o = hit ? data_q[index][hit_way] : NOP_INSTR;

    // Stale responses after a redirect are dropped here
    assign fill = rsp_valid_i && !hit && (rsp_i.addr == line_addr);

    assign touch_en  = (hit && accept_i) || fill;
    assign touch_way = fill ? victim_way : hit_way;

    assign req_valid_o = !hit && !pending_q;
    assign req_o.addr  = line_addr;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    age_q[s][w]   <= WAY_BITS'(w);  // Distinct ages to start
                end
            end
        end else begin
            if (req_valid_o && req_ready_i) begin
                pending_q <= 1'b1;
            end else if (rsp_valid_i) begin
                pending_q <= 1'b0;
            end

            if (fill) begin
                valid_q[index][victim_way] <= 1'b1;
            end

            // Used way goes to age 0, younger ways age by one
            if (touch_en) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (WAY_BITS'(w) == touch_way) begin
                        age_q[index][w] <= '0;
                    end else if (age_q[index][w] < age_q[index][touch_way]) begin
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill) begin
            tag_q[index][victim_way]  <= tag;
            data_q[index][victim_way] <= rsp_i.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/axil_fetch_master.sv
`default_nettype none

module axil_fetch_master (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  fetch_pkg::mem_req_t req_i,
    output logic                rsp_valid_o,
    output fetch_pkg::mem_rsp_t rsp_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    output fetch_pkg::axil_ar_t ar_o,
    input  logic                rvalid_i,
    output logic                rready_o,
    input  fetch_pkg::axil_r_t  r_i
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_e;

    state_e   state_q;
    bus32_t   addr_q;
    mem_rsp_t rsp_q;
    logic     rsp_valid_q;

    assign req_ready_o = (state_q == ST_IDLE);
    assign arvalid_o   = (state_q == ST_ADDR);
    assign rready_o    = (state_q == ST_DATA);

    assign ar_o.araddr = addr_q;  // Held from acceptance until R
    assign ar_o.arprot = AXI_PROT_INSTR;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready_i) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid_i) begin
                        state_q     <= ST_IDLE;
                        rsp_valid_q <= 1'b1;  // Single-cycle pulse
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            addr_q <= req_i.addr;
        end
        if (rvalid_i && rready_o) begin
            rsp_q.addr     <= addr_q;
            rsp_q.data.raw <= r_i.rdata;  // rresp ignored
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`default_nettype none

module fetch_top #(
    parameter int NUM_SETS = 16,
    parameter int WAYS     = 2  // Power of two
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  redirect_valid_i,
    input  fetch_pkg::bus32_t     redirect_pc_i,
    output fetch_pkg::fetch_out_t out_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic                  arvalid_o,
    input  logic                  arready_i,
    output fetch_pkg::axil_ar_t   ar_o,
    input  logic                  rvalid_i,
    output logic                  rready_o,
    input  fetch_pkg::axil_r_t    r_i
);
    import fetch_pkg::*;

    bus32_t   pc;
    instr_u   instr;
    logic     hit;
    logic     accept;
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     rsp_valid;
    mem_rsp_t rsp;

    assign accept = out_valid_o && out_ready_i;  // Decode took the word

    pc_gen pc_gen0 (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .hit_i            (hit),
        .instr_i          (instr),
        .out_ready_i      (out_ready_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .pc_o             (pc),
        .out_o            (out_o),
        .out_valid_o      (out_valid_o)
    );

    icache #(
        .NUM_SETS (NUM_SETS),
        .WAYS     (WAYS)
    ) icache0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pc_i        (pc),
        .accept_i    (accept),
        .hit_o       (hit),
        .instr_o     (instr),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready),
        .req_o       (req),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp)
    );

    axil_fetch_master axil_master0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .ar_o        (ar_o),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .r_i         (r_i)
    );

endmodule

`default_nettype wire

// File: tests/fetch_chk.sv
`default_nettype none

module fetch_chk (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                req_valid_i,
    input  logic                req_ready_o,
    input  logic                rsp_valid_o,
    input  logic                arvalid_o,
    input  logic                arready_i,
    input  fetch_pkg::axil_ar_t ar_o,
    input  logic                rvalid_i,
    input  logic                rready_o
);

    // AR channel holds until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
        else $error("AR channel changed before ARREADY");

    // RREADY only after an AR handshake and until R arrives
    ar_r_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rready_o |-> !arvalid_o &&
            ($past(arvalid_o && arready_i) || $past(rready_o && !rvalid_i)))
        else $error("RREADY high outside the wait for R");

    // Response pulse only after a completed read
    rsp_after_r: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o |-> $past(rvalid_i && rready_o))
        else $error("Response without R handshake");

    // Busy from acceptance until the R handshake
    busy_not_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((req_valid_i && req_ready_o) || arvalid_o || (rready_o && !rvalid_i))
            |=> !req_ready_o)
        else $error("Request accepted during open transaction");

endmodule

bind axil_fetch_master fetch_chk chk0 (.*);

`default_nettype wire

// File: tests/fetch_tb.sv
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int N_RANDOM  = 2000;
    localparam int N_NOREDIR = 1000;
    localparam int MISS_LAT  = 12;  // Worst case AR plus R delay plus FSM overhead

    logic       clk;
    logic       rstn;
    logic       redirect_valid;
    bus32_t     redirect_pc;
    fetch_out_t out;
    logic       out_valid;
    logic       out_ready;
    logic       arvalid;
    logic       arready;
    axil_ar_t   ar;
    logic       rvalid;
    logic       rready;
    axil_r_t    r_bus;

    logic [31:0] mem [64];
    int          ar_count [64];
    int          error_count;
    int          check_count;
    logic [31:0] stim_seed;
    logic [31:0] axi_seed;
    bus32_t      exp_pc;
    logic        bp_pending;
    fetch_out_t  bp_out;
    logic        r_busy;
    bus32_t      r_addr;
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;

    fetch_top dut0 (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .out_o            (out),
        .out_valid_o      (out_valid),
        .out_ready_i      (out_ready),
        .arvalid_o        (arvalid),
        .arready_i        (arready),
        .ar_o             (ar),
        .rvalid_i         (rvalid),
        .rready_o         (rready),
        .r_i              (r_bus)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encode_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'h6f};
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        error_count++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
    endtask

    task automatic draw(output logic [31:0] v);
        stim_seed = xorshift32(stim_seed);
        v = stim_seed;
    endtask

    // JALs in words 0..31 target only words 0..31
    task automatic build_image();
        logic [31:0] v;
        int          t;
        for (int i = 0; i < 64; i++) begin
            draw(v);
            if (i == 31 || i == 63 || (v[1:0] == 2'b00 && i != 0 && i != 16 && i != 32)) begin
                t = (i < 32) ? int'(v[8:4]) : int'(v[9:4]);
                mem[i] = encode_jal((t - i) * 4);
            end else begin
                mem[i] = {v[31:7], 7'h13};
            end
        end
    endtask

    task automatic drain();
        do @(negedge clk); while (!(out_valid && !arvalid && !rready));
        repeat (2) @(negedge clk);
    endtask

    task automatic goto(input bus32_t a);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= a;
        out_ready      <= 1'b0;
        @(posedge clk);
        redirect_valid <= 1'b0;
        out_ready      <= 1'b1;
        do @(posedge clk); while (!(out_valid && out_ready));
        out_ready <= 1'b0;
    endtask

    task automatic run_random(input int cycles, input logic allow_redirect);
        logic [31:0] v;
        repeat (cycles) begin
            @(posedge clk);
            draw(v);
            out_ready      <= v[0] | v[1];
            redirect_valid <= allow_redirect && (v[7:4] == 4'h0);
            redirect_pc    <= {24'h0, v[13:8], 2'b00};
        end
    endtask

    // Reference model samples before the edge updates anything
    always @(posedge clk) begin
        if (rstn) begin
            if (bp_pending) begin
                check_count++;
                assert (out_valid && out == bp_out)
                    else report_mismatch("backpressure_hold", bp_out, out);
            end
            bp_pending <= out_valid && !out_ready && !redirect_valid;
            bp_out     <= out;
            if (out_valid && out_ready) begin
                check_count++;
                assert (out.pc == exp_pc) else report_mismatch("fetch_pc", exp_pc, out.pc);
                assert (out.instr.raw == mem[exp_pc[7:2]])
                    else report_mismatch("fetch_instr", mem[exp_pc[7:2]], out.instr.raw);
                if (mem[exp_pc[7:2]][6:0] == 7'h6f) begin
                    exp_pc = exp_pc + jal_offset(mem[exp_pc[7:2]]);
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end
        end
    end

    // AXI4-Lite read slave with random delays
    always @(posedge clk) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r_busy  <= 1'b0;
            ar_wait <= 2'd0;
            r_wait  <= 2'd0;
        end else begin
            axi_seed = xorshift32(axi_seed);
            arready <= 1'b0;
            if (arvalid && arready) begin
                check_count++;
                assert (ar.araddr[1:0] == 2'b00 && ar.araddr[31:8] == 24'h0)
                    else begin
                        error_count++;
                        $display("Unaligned or out of range read address %h", ar.araddr);
                    end
                assert (ar.arprot == 3'b100) else report_mismatch("arprot", 3'b100, ar.arprot);
                ar_count[ar.araddr[7:2]] = ar_count[ar.araddr[7:2]] + 1;
                r_busy  <= 1'b1;
                r_addr  <= ar.araddr;
                r_wait  <= axi_seed[1:0];
                ar_wait <= axi_seed[3:2];
            end else if (arvalid && !r_busy) begin
                if (ar_wait == 2'd0) arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_busy <= 1'b0;
            end else if (r_busy && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid       <= 1'b1;
                    r_bus.rdata  <= mem[r_addr[7:2]];
                    r_bus.rresp  <= 2'b00;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end
    end

    initial begin
        #((N_RANDOM + N_NOREDIR + 200) * MISS_LAT * 20);
        $display("Timeout: the run did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        out_ready = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        r_bus = '0;
        error_count = 0;
        check_count = 0;
        exp_pc = RESET_PC;
        bp_pending = 1'b0;
        stim_seed = 32'h534c;
        axi_seed = 32'h534c ^ 32'h9e37_0000;
        foreach (ar_count[i]) ar_count[i] = 0;
        build_image();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        run_random(N_RANDOM, 1'b1);

        // Closed 32-word loop fills the cache exactly
        goto(32'h0);
        drain();
        foreach (ar_count[i]) ar_count[i] = 0;
        run_random(N_NOREDIR, 1'b0);
        drain();
        foreach (ar_count[i]) begin
            assert (ar_count[i] <= 1)
                else report_mismatch("ar_once", 1, ar_count[i]);
        end

        // 0x40 becomes the LRU victim of 0x80 in set 0
        goto(32'h00);
        goto(32'h40);
        goto(32'h00);
        goto(32'h80);
        @(negedge clk);
        foreach (ar_count[i]) ar_count[i] = 0;
        goto(32'h00);
        goto(32'h40);
        assert (ar_count[0] == 0) else report_mismatch("retained_refetch", 0, ar_count[0]);
        assert (ar_count[16] == 1) else report_mismatch("evicted_refetch", 1, ar_count[16]);
        drain();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/icache.sv
logic/axil_fetch_master.sv
logic/fetch_top.sv
tests/fetch_chk.sv
tests/fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
